//--- sim.f
cc_pkg.sv
cc_control.sv
frame_loader.sv
lag_correlator.sv
peak_tracker.sv
cc_block.sv
cc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cross-correlation testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module cc_tb -o cc_tb_sim

out=$(./obj_dir/cc_tb_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
  exit 0
fi
exit 1

//--- cc_tb.sv
// testbench for cc_block: ring-buffer model, lfsr frames,
// reference correlation and concurrent checks
`timescale 1ns/100ps
`default_nettype none

module cc_tb;

  localparam int NUM_RUNS   = 5;
  localparam int DRV_DLY    = 10;                 // ns after rising edge
  localparam int DELAY      = 3;                  // y trails x in the delayed run
  localparam int DELAY_LAG  = cc_pkg::PAD_LEN - (cc_pkg::FRAME_LEN - DELAY);
  localparam int X_BASE     = cc_pkg::PAD_LEN - cc_pkg::FRAME_LEN; // x in upper half
  localparam int RUN_CYCLES = cc_pkg::FRAME_LEN + cc_pkg::PAD_LEN * cc_pkg::PAD_LEN + 60;
  localparam int MAX_CYCLES = NUM_RUNS * RUN_CYCLES + 2500;

  logic                              clk;
  logic                              rst_n;
  logic                              start_cc;
  logic [cc_pkg::WORD_W-1:0]         ring_x;
  logic [cc_pkg::WORD_W-1:0]         ring_y;
  logic                              send_frame_x;
  logic                              send_frame_y;
  logic [cc_pkg::LAG_W-1:0]          index_out;
  logic                              cc_done;
  logic                              corr_valid;
  logic [cc_pkg::LAG_W-1:0]          corr_lag;
  logic signed [cc_pkg::ACC_W-1:0]   corr_value;

  logic [cc_pkg::WORD_W-1:0]         x_words [cc_pkg::FRAME_LEN];   // ring contents
  logic [cc_pkg::WORD_W-1:0]         y_words [cc_pkg::FRAME_LEN];
  logic signed [cc_pkg::ACC_W-1:0]   ref_r [cc_pkg::PAD_LEN];       // expected r(k)
  logic [cc_pkg::LAG_W-1:0]          exp_index;                     // expected argmax
  logic                              delay_run;
  logic [31:0]                       lfsr_state;

  logic                              started;     // first start issued
  logic                              tb_busy;     // run accepted, no done yet
  logic [5:0]                        lag_cnt;     // lags seen this run
  logic                              held;        // index must stay put
  logic [cc_pkg::LAG_W-1:0]          held_index;
  int                                cycle_cnt;
  int                                done_cnt;

  cc_block i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_cc     (start_cc),
    .ring_x       (ring_x),
    .ring_y       (ring_y),
    .send_frame_x (send_frame_x),
    .send_frame_y (send_frame_y),
    .index_out    (index_out),
    .cc_done      (cc_done),
    .corr_valid   (corr_valid),
    .corr_lag     (corr_lag),
    .corr_value   (corr_value)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                       // 100 ns period
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, taps 32,22,2,1
  endfunction

  // one lfsr step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // runs 0..2 random, 3 delayed copy, 4 all zero; upper halves always random
  task automatic make_frames(input int run);
    logic [31:0] w;
    for (int i = 0; i < cc_pkg::FRAME_LEN; i++) begin
      rand_bits(32, w);
      x_words[i] = w;
      rand_bits(32, w);
      y_words[i] = w;
    end
    delay_run = (run == 3);
    if (run == 3) begin
      for (int i = 0; i < cc_pkg::FRAME_LEN; i++) begin
        if (i >= cc_pkg::FRAME_LEN - DELAY)
          x_words[i][cc_pkg::SAMPLE_W-1:0] = '0;  // whole x fits in delayed y
        if (i >= DELAY)
          y_words[i][cc_pkg::SAMPLE_W-1:0] = x_words[i-DELAY][cc_pkg::SAMPLE_W-1:0];
        else
          y_words[i][cc_pkg::SAMPLE_W-1:0] = '0;
      end
    end else if (run == 4) begin
      for (int i = 0; i < cc_pkg::FRAME_LEN; i++) begin
        x_words[i][cc_pkg::SAMPLE_W-1:0] = '0;
        y_words[i][cc_pkg::SAMPLE_W-1:0] = '0;
      end
    end
  endtask

  // padded frames, r(k) = sum xp(n) * yp((n+k) mod 32), strict-greater argmax
  task automatic compute_reference();
    longint xp [cc_pkg::PAD_LEN];
    longint yp [cc_pkg::PAD_LEN];
    longint sum;
    longint best;
    for (int n = 0; n < cc_pkg::PAD_LEN; n++) begin
      xp[n] = 0;
      yp[n] = 0;
    end
    for (int i = 0; i < cc_pkg::FRAME_LEN; i++) begin
      xp[X_BASE+i] = longint'($signed(x_words[i][cc_pkg::SAMPLE_W-1:0]));
      yp[i]        = longint'($signed(y_words[i][cc_pkg::SAMPLE_W-1:0]));
    end
    best = 0;
    exp_index = '0;
    for (int k = 0; k < cc_pkg::PAD_LEN; k++) begin
      sum = 0;
      for (int n = 0; n < cc_pkg::PAD_LEN; n++) begin
        sum += xp[n] * yp[(n + k) % cc_pkg::PAD_LEN];
      end
      ref_r[k] = cc_pkg::ACC_W'(sum);
      if (k == 0 || sum > best) begin           // earliest lag keeps a tie
        best      = sum;
        exp_index = cc_pkg::LAG_W'(k);
      end
    end
  endtask

  // ring buffer: frame words on the cycles after send_frame
  initial begin
    ring_x = '0;
    ring_y = '0;
    forever begin
      @(posedge clk);
      #DRV_DLY;
      if (send_frame_x) begin
        for (int i = 0; i < cc_pkg::FRAME_LEN; i++) begin
          @(posedge clk);
          #DRV_DLY;
          ring_x = x_words[i];
          ring_y = y_words[i];
        end
      end else begin
        ring_x = 32'h5a5a_7fff;                   // junk outside a frame
        ring_y = 32'ha5a5_8001;
      end
    end
  end

  // expected run state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tb_busy    <= 1'b0;
      lag_cnt    <= '0;
      held       <= 1'b0;
      held_index <= '0;
      done_cnt   <= 0;
    end else if (start_cc && !tb_busy) begin
      tb_busy <= 1'b1;                            // accepted start
      lag_cnt <= '0;
      held    <= 1'b0;
    end else begin
      if (corr_valid)
        lag_cnt <= lag_cnt + 1'b1;
      if (cc_done) begin
        tb_busy    <= 1'b0;
        held       <= 1'b1;
        held_index <= exp_index;
        done_cnt   <= done_cnt + 1;
      end
    end
  end

  task automatic run_once(input int poke_at);
    int waited;
    start_cc = 1'b1;
    started  = 1'b1;
    @(posedge clk);
    #DRV_DLY;
    start_cc = 1'b0;
    waited = 1;
    while (!cc_done) begin
      @(posedge clk);
      #DRV_DLY;
      waited++;
      start_cc = (poke_at != 0 && waited == poke_at);  // start while busy
    end
    start_cc = 1'b0;
    repeat (8) @(posedge clk);                    // idle gap, index held
    #DRV_DLY;
  endtask

  initial begin
    rst_n      = 1'b0;
    start_cc   = 1'b0;
    started    = 1'b0;
    delay_run  = 1'b0;
    exp_index  = '0;
    lfsr_state = 32'h1b29_d0ad;
    repeat (16) @(posedge clk);
    #DRV_DLY;
    rst_n = 1'b1;
    repeat (6) @(posedge clk);                    // quiet window after reset
    #DRV_DLY;
    for (int run = 0; run < NUM_RUNS; run++) begin
      make_frames(run);
      compute_reference();
      run_once(run == 1 ? 5 : (run == 2 ? 300 : 0));  // pokes in load, correlate
    end
    if (done_cnt == NUM_RUNS) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run($sformatf("only %0d of %0d runs finished", done_cnt, NUM_RUNS));
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    abort_run($sformatf("timeout, test still running after %0d cycles", cycle_cnt));
  end

  a_quiet_before_start: assert property (
    @(posedge clk) disable iff (!rst_n)
    !started |-> (!send_frame_x && !send_frame_y && !cc_done && !corr_valid && index_out == '0)
  ) else abort_run($sformatf(
    "ERROR before start send_frame_x=%h send_frame_y=%h cc_done=%h corr_valid=%h index_out=%h",
    $sampled(send_frame_x), $sampled(send_frame_y), $sampled(cc_done),
    $sampled(corr_valid), $sampled(index_out)));

  a_frames_together: assert property (
    @(posedge clk) disable iff (!rst_n)
    send_frame_x == send_frame_y
  ) else abort_run($sformatf("ERROR send_frame_x=%h send_frame_y=%h",
    $sampled(send_frame_x), $sampled(send_frame_y)));

  a_frame_after_start: assert property (
    @(posedge clk) disable iff (!rst_n)
    (start_cc && !tb_busy) |=> send_frame_x
  ) else abort_run($sformatf("ERROR send_frame_x=%h expected 1 after start",
    $sampled(send_frame_x)));

  a_no_extra_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    send_frame_x |-> $past(start_cc && !tb_busy)
  ) else abort_run("send_frame pulsed without an accepted start");

  a_lag_order: assert property (
    @(posedge clk) disable iff (!rst_n)
    corr_valid |-> (corr_lag == cc_pkg::LAG_W'(lag_cnt))
  ) else abort_run($sformatf("ERROR corr_lag=%h expected %h",
    $sampled(corr_lag), $sampled(lag_cnt)));

  a_lag_value: assert property (
    @(posedge clk) disable iff (!rst_n)
    corr_valid |-> (corr_value == ref_r[lag_cnt[cc_pkg::ADDR_W-1:0]])
  ) else abort_run($sformatf("ERROR corr_value=%h expected %h at lag %h",
    $sampled(corr_value), ref_r[$sampled(lag_cnt[cc_pkg::ADDR_W-1:0])], $sampled(lag_cnt)));

  a_done_after_lags: assert property (
    @(posedge clk) disable iff (!rst_n)
    cc_done |-> (tb_busy && lag_cnt == 6'(cc_pkg::PAD_LEN))
  ) else abort_run($sformatf("ERROR cc_done=%h with lag count %h, busy %h",
    $sampled(cc_done), $sampled(lag_cnt), $sampled(tb_busy)));

  a_index_at_done: assert property (
    @(posedge clk) disable iff (!rst_n)
    cc_done |-> (index_out == exp_index)
  ) else abort_run($sformatf("ERROR index_out=%h expected %h",
    $sampled(index_out), $sampled(exp_index)));

  a_delay_lag: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cc_done && delay_run) |-> (index_out == cc_pkg::LAG_W'(DELAY_LAG))
  ) else abort_run($sformatf("ERROR index_out=%h expected %h for delayed copy",
    $sampled(index_out), cc_pkg::LAG_W'(DELAY_LAG)));

  a_index_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    held |-> (index_out == held_index)
  ) else abort_run($sformatf("ERROR index_out=%h expected held %h",
    $sampled(index_out), $sampled(held_index)));

endmodule : cc_tb

`default_nettype wire

//--- cc_block.sv
// cross-correlation top with sequencer, two frame loaders,
// mac correlator and argmax
`timescale 1ns/100ps
`default_nettype none

module cc_block (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  start_cc,
  input  wire  [cc_pkg::WORD_W-1:0]            ring_x,
  input  wire  [cc_pkg::WORD_W-1:0]            ring_y,
  output logic                                 send_frame_x,
  output logic                                 send_frame_y,
  output logic [cc_pkg::LAG_W-1:0]             index_out,   // persists after the run
  output logic                                 cc_done,
  output logic                                 corr_valid,  // observation port
  output logic [cc_pkg::LAG_W-1:0]             corr_lag,
  output logic signed [cc_pkg::ACC_W-1:0]      corr_value
);

  logic                              frame_req;
  logic                              peak_clear;
  logic                              corr_start;
  logic                              corr_done;
  logic [cc_pkg::ADDR_W-1:0]         rd_addr_x;
  logic [cc_pkg::ADDR_W-1:0]         rd_addr_y;
  logic signed [cc_pkg::SAMPLE_W-1:0] samp_x;
  logic signed [cc_pkg::SAMPLE_W-1:0] samp_y;

  cc_control i_control (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_cc   (start_cc),
    .corr_done  (corr_done),
    .frame_req  (frame_req),
    .peak_clear (peak_clear),
    .corr_start (corr_start),
    .cc_done    (cc_done),
    .busy       ()
  );

  // both ring buffers asked on the same cycle
  assign send_frame_x = frame_req;
  assign send_frame_y = frame_req;

  frame_loader #(.pad_front(1'b1)) i_load_x (   // x at the back of the store
    .clk       (clk),
    .rst_n     (rst_n),
    .frame_req (frame_req),
    .ring_word (ring_x),
    .rd_addr   (rd_addr_x),
    .rd_sample (samp_x)
  );

  frame_loader #(.pad_front(1'b0)) i_load_y (   // y at the front
    .clk       (clk),
    .rst_n     (rst_n),
    .frame_req (frame_req),
    .ring_word (ring_y),
    .rd_addr   (rd_addr_y),
    .rd_sample (samp_y)
  );

  lag_correlator i_corr (
    .clk        (clk),
    .rst_n      (rst_n),
    .corr_start (corr_start),
    .samp_x     (samp_x),
    .samp_y     (samp_y),
    .rd_addr_x  (rd_addr_x),
    .rd_addr_y  (rd_addr_y),
    .lag_valid  (corr_valid),
    .lag_index  (corr_lag),
    .lag_value  (corr_value),
    .corr_done  (corr_done)
  );

  peak_tracker i_peak (
    .clk        (clk),
    .rst_n      (rst_n),
    .peak_clear (peak_clear),
    .lag_valid  (corr_valid),
    .lag_index  (corr_lag),
    .lag_value  (corr_value),
    .max_index  (index_out)
  );

endmodule : cc_block

`default_nettype wire

//--- peak_tracker.sv
// running argmax over lag results, holds the winning lag index
`timescale 1ns/100ps
`default_nettype none

module peak_tracker (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  peak_clear,
  input  wire                                  lag_valid,
  input  wire  [cc_pkg::LAG_W-1:0]             lag_index,
  input  wire  signed [cc_pkg::ACC_W-1:0]      lag_value,
  output logic [cc_pkg::LAG_W-1:0]             max_index
);

  logic signed [cc_pkg::ACC_W-1:0] best_value;    // current maximum
  logic                            empty;         // nothing seen since clear
  logic                            take;

  // strict greater, so earliest lag wins a tie
  assign take = lag_valid && (empty || (lag_value > best_value));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      empty     <= 1'b1;
      max_index <= '0;
    end else if (peak_clear) begin
      empty <= 1'b1;                              // index held until new lags
    end else if (take) begin
      empty     <= 1'b0;
      max_index <= lag_index;
    end
  end

  always_ff @(posedge clk) begin
    if (take && !peak_clear) begin
      best_value <= lag_value;
    end
  end

endmodule : peak_tracker

`default_nettype wire

//--- lag_correlator.sv
// direct time-domain multiply-accumulate correlator producing one value per lag
// r(k) = sum_n xp(n) * yp((n+k) mod PAD_LEN)
`timescale 1ns/100ps
`default_nettype none

module lag_correlator (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  corr_start,
  input  wire  signed [cc_pkg::SAMPLE_W-1:0]   samp_x,
  input  wire  signed [cc_pkg::SAMPLE_W-1:0]   samp_y,
  output logic [cc_pkg::ADDR_W-1:0]            rd_addr_x,
  output logic [cc_pkg::ADDR_W-1:0]            rd_addr_y,
  output logic                                 lag_valid,
  output logic [cc_pkg::LAG_W-1:0]             lag_index,
  output logic signed [cc_pkg::ACC_W-1:0]      lag_value,
  output logic                                 corr_done
);

  logic                              active;      // engine running
  logic [cc_pkg::ADDR_W-1:0]         tap;         // n
  logic [cc_pkg::ADDR_W-1:0]         lag;         // k
  logic signed [cc_pkg::ACC_W-1:0]   acc;
  logic signed [cc_pkg::ACC_W-1:0]   prod;        // sign-extended product
  logic signed [cc_pkg::ACC_W-1:0]   acc_next;
  logic                              last_tap;
  logic                              last_lag;

  // y read address wraps naturally at PAD_LEN
  assign rd_addr_x = tap;
  assign rd_addr_y = tap + lag;

  assign prod     = samp_x * samp_y;              // signed operands in 40-bit context
  assign acc_next = acc + prod;
  assign last_tap = (tap == cc_pkg::ADDR_W'(cc_pkg::PAD_LEN - 1));
  assign last_lag = (lag == cc_pkg::ADDR_W'(cc_pkg::PAD_LEN - 1));

  // control counters and strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active    <= 1'b0;
      tap       <= '0;
      lag       <= '0;
      lag_valid <= 1'b0;
      corr_done <= 1'b0;
    end else begin
      lag_valid <= 1'b0;
      corr_done <= 1'b0;
      if (corr_start) begin
        active <= 1'b1;
        tap    <= '0;
        lag    <= '0;
      end else if (active) begin
        tap <= tap + 1'b1;                        // wraps to 0 after last tap
        if (last_tap) begin
          lag_valid <= 1'b1;                      // one result per PAD_LEN cycles
          lag       <= lag + 1'b1;
          if (last_lag) begin
            corr_done <= 1'b1;                    // alongside the final lag
            active    <= 1'b0;
          end
        end
      end
    end
  end

  // accumulator and result payload
  always_ff @(posedge clk) begin
    if (corr_start) begin
      acc <= '0;
    end else if (active) begin
      if (last_tap) begin
        lag_value <= acc_next;                    // include the final tap
        lag_index <= cc_pkg::LAG_W'(lag);
        acc       <= '0;                          // fresh sum for next lag
      end else begin
        acc <= acc_next;
      end
    end
  end

  a_lag_index_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    lag_valid |-> (lag_index < cc_pkg::LAG_W'(cc_pkg::PAD_LEN))
  ) else $error("lag_index out of range: %0h", lag_index);

endmodule : lag_correlator

`default_nettype wire

//--- frame_loader.sv
// one channel's frame capture into a zero-padded sample store
// with a combinational read port
`timescale 1ns/100ps
`default_nettype none

module frame_loader #(
  parameter bit pad_front = 1'b1                  // 1: samples in upper half
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  frame_req,
  input  wire  [cc_pkg::WORD_W-1:0]            ring_word,
  input  wire  [cc_pkg::ADDR_W-1:0]            rd_addr,
  output logic signed [cc_pkg::SAMPLE_W-1:0]   rd_sample
);

  logic signed [cc_pkg::SAMPLE_W-1:0] mem [cc_pkg::PAD_LEN];  // padded frame
  logic [cc_pkg::CNT_W-1:0]           wr_cnt;                 // FRAME_LEN means idle
  logic [cc_pkg::ADDR_W-1:0]          wr_addr;
  logic                               filling;

  assign filling = (wr_cnt < cc_pkg::CNT_W'(cc_pkg::FRAME_LEN));

  // top address bit picks the half, low bits walk the frame
  assign wr_addr = {pad_front, wr_cnt[cc_pkg::ADDR_W-2:0]};

  // write counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt <= cc_pkg::CNT_W'(cc_pkg::FRAME_LEN); // parked, nothing to write
    end else if (frame_req) begin
      wr_cnt <= '0;                               // first word on next edge
    end else if (filling) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  // sample store, no reset on the array
  always_ff @(posedge clk) begin
    if (frame_req) begin
      for (int i = 0; i < cc_pkg::FRAME_LEN; i++) begin
        mem[{~pad_front, (cc_pkg::ADDR_W-1)'(i)}] <= '0;  // clear the pad half
      end
    end else if (filling) begin
      mem[wr_addr] <= ring_word[cc_pkg::SAMPLE_W-1:0]; // upper half dropped
    end
  end

  assign rd_sample = mem[rd_addr];                // same-cycle read

  a_wr_cnt_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_cnt <= cc_pkg::CNT_W'(cc_pkg::FRAME_LEN)
  ) else $error("frame_loader write counter past FRAME_LEN: %0d", wr_cnt);

endmodule : frame_loader

`default_nettype wire

//--- cc_control.sv
// run sequencer: frame request, peak clear, correlation start
// and the end-of-run done pulse
`timescale 1ns/100ps
`default_nettype none

module cc_control (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  start_cc,                          // one-cycle request, idle only
  input  wire  corr_done,                         // last lag out of correlator
  output logic frame_req,                         // to loaders and send_frame pins
  output logic peak_clear,                        // re-arm argmax
  output logic corr_start,                        // kick the mac engine
  output logic cc_done,                           // end of run
  output logic busy
);

  cc_pkg::cc_state_e            state;
  logic [cc_pkg::CNT_W-1:0]     load_cnt;         // cycles spent in load

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= cc_pkg::st_idle;
      load_cnt   <= '0;
      frame_req  <= 1'b0;
      peak_clear <= 1'b0;
      corr_start <= 1'b0;
      cc_done    <= 1'b0;
    end else begin
      frame_req  <= 1'b0;                         // all strobes default low
      peak_clear <= 1'b0;
      corr_start <= 1'b0;
      cc_done    <= 1'b0;
      case (state)
        cc_pkg::st_idle: begin
          if (start_cc) begin                     // only accepted here
            state      <= cc_pkg::st_load;
            load_cnt   <= '0;
            frame_req  <= 1'b1;                   // one cycle after start
            peak_clear <= 1'b1;
          end
        end
        cc_pkg::st_load: begin
          // req cycle plus FRAME_LEN word cycles, then the stores are full
          if (load_cnt == cc_pkg::CNT_W'(cc_pkg::FRAME_LEN)) begin
            state      <= cc_pkg::st_correlate;
            corr_start <= 1'b1;
          end else begin
            load_cnt <= load_cnt + 1'b1;
          end
        end
        cc_pkg::st_correlate: begin
          if (corr_done) begin                    // peak tracker folds it this edge
            state   <= cc_pkg::st_report;
            cc_done <= 1'b1;
          end
        end
        cc_pkg::st_report: begin
          state <= cc_pkg::st_idle;               // single report cycle
        end
        default: state <= cc_pkg::st_idle;
      endcase
    end
  end

  assign busy = (state != cc_pkg::st_idle);

  // one request per run, never stretched
  a_frame_req_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    frame_req |=> !frame_req
  ) else $error("frame_req held for two cycles");

  // done only ever comes straight after the correlator finishes
  a_done_after_corr: assert property (
    @(posedge clk) disable iff (!rst_n)
    cc_done |-> $past(corr_done)
  ) else $error("cc_done without preceding corr_done");

endmodule : cc_control

`default_nettype wire

//--- cc_pkg.sv
// shared sizes, widths and control state encoding for the
// time-domain cross-correlation block
`default_nettype none

package cc_pkg;

  // frame geometry
  localparam int FRAME_LEN = 16;                  // samples per channel frame
  localparam int PAD_LEN   = 32;                  // padded length, also lag count

  // datapath widths
  localparam int SAMPLE_W  = 16;                  // signed sample, low half of ring word
  localparam int WORD_W    = 32;                  // ring-buffer word
  localparam int ADDR_W    = 5;                   // sample store address
  localparam int LAG_W     = 8;                   // lag index port width
  localparam int ACC_W     = 40;                  // signed accumulator / corr value
  localparam int CNT_W     = $clog2(FRAME_LEN + 1); // counts 0..FRAME_LEN inclusive

  // run sequencer states
  typedef enum logic [1:0] {
    st_idle      = 2'd0,                          // waiting for start
    st_load      = 2'd1,                          // frames streaming in
    st_correlate = 2'd2,                          // mac engine running
    st_report    = 2'd3                           // done pulse out
  } cc_state_e;

endpackage : cc_pkg

`default_nettype wire
